// ==== hdl/mipsPkg.sv ====
package mipsPkg;

	// Primary opcodes, instr[31:26]
	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opJ     = 6'h02;
	localparam logic [5:0] opBeq   = 6'h04;
	localparam logic [5:0] opBne   = 6'h05;
	localparam logic [5:0] opAddi  = 6'h08;
	localparam logic [5:0] opSlti  = 6'h0A;
	localparam logic [5:0] opAndi  = 6'h0C;
	localparam logic [5:0] opOri   = 6'h0D;
	localparam logic [5:0] opXori  = 6'h0E;
	localparam logic [5:0] opLui   = 6'h0F;
	localparam logic [5:0] opLw    = 6'h23;
	localparam logic [5:0] opSw    = 6'h2B;

	// R-type function field, instr[5:0]
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr  = 6'h25;
	localparam logic [5:0] fnXor = 6'h26;
	localparam logic [5:0] fnNor = 6'h27;
	localparam logic [5:0] fnSlt = 6'h2A;

	// ALU operation select
	localparam logic [3:0] aluAdd = 4'd0;
	localparam logic [3:0] aluSub = 4'd1;
	localparam logic [3:0] aluAnd = 4'd2;
	localparam logic [3:0] aluOr  = 4'd3;
	localparam logic [3:0] aluXor = 4'd4;
	localparam logic [3:0] aluNor = 4'd5;
	localparam logic [3:0] aluSlt = 4'd6;
	localparam logic [3:0] aluLui = 4'd7;

	// Operation class from the FSM to the ALU decoder
	localparam logic [1:0] aluOpAdd    = 2'b00;
	localparam logic [1:0] aluOpSub    = 2'b01;
	localparam logic [1:0] aluOpFunct  = 2'b10;
	localparam logic [1:0] aluOpOpcode = 2'b11;

	// FSM states, preFetch is the entry state
	typedef enum logic [3:0] {
		fetch          = 4'd0,
		decode         = 4'd1,
		memAdr         = 4'd2,
		memRead        = 4'd3,
		memWriteback   = 4'd4,
		memWrite       = 4'd5,
		execute        = 4'd6,
		aluWriteback   = 4'd7,
		branch         = 4'd8,
		itypeExecute   = 4'd9,
		itypeWriteback = 4'd10,
		jump           = 4'd11,
		preFetch       = 4'd12
	} ctrlState;

	// Three views of one instruction word
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFormat;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} iFormat;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target;
	} jFormat;

	typedef union packed {
		rFormat rFields;
		iFormat iFields;
		jFormat jFields;
	} instrWord;

	// Control bundle, FSM to datapath
	typedef struct packed {
		logic       memToReg;
		logic       iOrD;
		logic [1:0] regDst;
		logic [1:0] pcSrc;
		logic       aluSrcA;
		logic [1:0] aluSrcB;
		logic       irWrite;
		logic       memWrite;
		logic       pcWrite;
		logic       regWrite;
		// Bit 1 bne, bit 0 beq
		logic [1:0] branch;
		logic       extOp;
		logic [3:0] aluControl;
	} ctrlSignals;

endpackage

// ==== hdl/aluDecoder.sv ====
module aluDecoder (
	input  logic [5:0] code,
	input  logic [1:0] aluOp,
	output logic [3:0] aluControl
);

	always_comb begin
		// Fallback for unlisted codes
		aluControl = mipsPkg::aluAdd;
		case (aluOp)
			mipsPkg::aluOpAdd: aluControl = mipsPkg::aluAdd;
			mipsPkg::aluOpSub: aluControl = mipsPkg::aluSub;
			// R-type, code is the funct field
			mipsPkg::aluOpFunct: begin
				case (code)
					mipsPkg::fnAdd: aluControl = mipsPkg::aluAdd;
					mipsPkg::fnSub: aluControl = mipsPkg::aluSub;
					mipsPkg::fnAnd: aluControl = mipsPkg::aluAnd;
					mipsPkg::fnOr:  aluControl = mipsPkg::aluOr;
					mipsPkg::fnXor: aluControl = mipsPkg::aluXor;
					mipsPkg::fnNor: aluControl = mipsPkg::aluNor;
					mipsPkg::fnSlt: aluControl = mipsPkg::aluSlt;
					default:        aluControl = mipsPkg::aluAdd;
				endcase
			end
			// I-type, code is the opcode
			mipsPkg::aluOpOpcode: begin
				case (code)
					mipsPkg::opAddi: aluControl = mipsPkg::aluAdd;
					mipsPkg::opSlti: aluControl = mipsPkg::aluSlt;
					mipsPkg::opAndi: aluControl = mipsPkg::aluAnd;
					mipsPkg::opOri:  aluControl = mipsPkg::aluOr;
					mipsPkg::opXori: aluControl = mipsPkg::aluXor;
					mipsPkg::opLui:  aluControl = mipsPkg::aluLui;
					default:         aluControl = mipsPkg::aluAdd;
				endcase
			end
			default: aluControl = mipsPkg::aluAdd;
		endcase
	end

endmodule

// ==== hdl/alu.sv ====
module alu (
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  logic [3:0]  aluControl,
	output logic [31:0] result,
	output logic        zero
);

	always_comb begin
		case (aluControl)
			mipsPkg::aluAdd: result = a + b;
			mipsPkg::aluSub: result = a - b;
			mipsPkg::aluAnd: result = a & b;
			mipsPkg::aluOr:  result = a | b;
			mipsPkg::aluXor: result = a ^ b;
			mipsPkg::aluNor: result = ~(a | b);
			// Signed compare, 1 or 0
			mipsPkg::aluSlt: begin
				result = {31'b0, $signed(a) < $signed(b)};
			end
			// Immediate goes to the upper half
			mipsPkg::aluLui: result = {b[15:0], 16'b0};
			default:         result = a + b;
		endcase
	end

	// Drives beq and bne
	assign zero = (result == 32'b0);

endmodule

// ==== hdl/regFile.sv ====
module regFile (
	input  logic        cclk,
	input  logic        rstb,
	input  logic [4:0]  readAddr1,
	input  logic [4:0]  readAddr2,
	input  logic [4:0]  writeAddr,
	input  logic [31:0] writeData,
	input  logic        writeEn,
	output logic [31:0] readData1,
	output logic [31:0] readData2
);

	logic [31:0] regs [31:0];

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'b0;
			end
		end else if (writeEn && (writeAddr != 5'd0)) begin
			// Register zero never written
			regs[writeAddr] <= writeData;
		end
	end

	// Asynchronous reads, zero hardwired
	assign readData1 = (readAddr1 == 5'd0) ? 32'b0 : regs[readAddr1];
	assign readData2 = (readAddr2 == 5'd0) ? 32'b0 : regs[readAddr2];

endmodule

// ==== hdl/controlUnit.sv ====
module controlUnit (
	input  logic                cclk,
	input  logic                rstb,
	input  mipsPkg::instrWord   instr,
	output mipsPkg::ctrlSignals ctrl
);

	mipsPkg::ctrlState state;
	mipsPkg::ctrlState nextState;
	logic [5:0] opcode;
	logic [5:0] decCode;
	logic [1:0] aluOp;
	logic [3:0] aluControl;

	assign opcode = instr.rFields.opcode;

	// Opcode feeds the decoder only in I-type execute
	assign decCode = (state == mipsPkg::itypeExecute) ? opcode : instr.rFields.funct;

	aluDecoder aluDec (
		.code      (decCode),
		.aluOp     (aluOp),
		.aluControl(aluControl)
	);

	// State register
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			state <= mipsPkg::preFetch;
		end else begin
			state <= nextState;
		end
	end

	// Next state
	always_comb begin
		nextState = mipsPkg::preFetch;
		case (state)
			mipsPkg::preFetch: nextState = mipsPkg::fetch;
			mipsPkg::fetch:    nextState = mipsPkg::decode;
			// Dispatch on opcode
			mipsPkg::decode: begin
				case (opcode)
					mipsPkg::opLw, mipsPkg::opSw: nextState = mipsPkg::memAdr;
					mipsPkg::opRType:             nextState = mipsPkg::execute;
					mipsPkg::opBeq, mipsPkg::opBne: nextState = mipsPkg::branch;
					mipsPkg::opAddi, mipsPkg::opSlti, mipsPkg::opAndi,
					mipsPkg::opOri, mipsPkg::opXori, mipsPkg::opLui: begin
						nextState = mipsPkg::itypeExecute;
					end
					mipsPkg::opJ: nextState = mipsPkg::jump;
					// Unknown opcode, no-op
					default: nextState = mipsPkg::preFetch;
				endcase
			end
			// Only lw and sw get here
			mipsPkg::memAdr: begin
				if (opcode == mipsPkg::opLw) begin
					nextState = mipsPkg::memRead;
				end else begin
					nextState = mipsPkg::memWrite;
				end
			end
			mipsPkg::memRead:      nextState = mipsPkg::memWriteback;
			mipsPkg::execute:      nextState = mipsPkg::aluWriteback;
			mipsPkg::itypeExecute: nextState = mipsPkg::itypeWriteback;
			// Last cycle of every instruction
			default: nextState = mipsPkg::preFetch;
		endcase
	end

	// ALU operation class by state
	always_comb begin
		case (state)
			mipsPkg::execute:      aluOp = mipsPkg::aluOpFunct;
			mipsPkg::itypeExecute: aluOp = mipsPkg::aluOpOpcode;
			// Compare rs and rt
			mipsPkg::branch:       aluOp = mipsPkg::aluOpSub;
			default:               aluOp = mipsPkg::aluOpAdd;
		endcase
	end

	// Moore outputs
	always_comb begin
		ctrl = '0;
		ctrl.aluControl = aluControl;
		// Logic immediates are zero extended
		ctrl.extOp = !(opcode inside {mipsPkg::opAndi, mipsPkg::opOri, mipsPkg::opXori});
		case (state)
			// PC out to memory, PC+4 back into PC
			mipsPkg::preFetch: begin
				ctrl.aluSrcB = 2'b01;
				ctrl.pcWrite = 1'b1;
			end
			// Instruction word arrives
			mipsPkg::fetch: begin
				ctrl.irWrite = 1'b1;
			end
			// Branch target, PC already advanced
			mipsPkg::decode: begin
				ctrl.aluSrcB = 2'b11;
			end
			// rs plus offset
			mipsPkg::memAdr: begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = 2'b10;
			end
			mipsPkg::memRead: begin
				ctrl.iOrD = 1'b1;
			end
			// Load data into rt
			mipsPkg::memWriteback: begin
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			mipsPkg::memWrite: begin
				ctrl.iOrD     = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			mipsPkg::execute: begin
				ctrl.aluSrcA = 1'b1;
			end
			// Result into rd
			mipsPkg::aluWriteback: begin
				ctrl.regDst   = 2'd1;
				ctrl.regWrite = 1'b1;
			end
			// Target held in the ALU result register
			mipsPkg::branch: begin
				ctrl.aluSrcA = 1'b1;
				ctrl.pcSrc   = 2'b01;
				ctrl.branch  = {opcode == mipsPkg::opBne, opcode == mipsPkg::opBeq};
			end
			mipsPkg::itypeExecute: begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = 2'b10;
			end
			// Result into rt
			mipsPkg::itypeWriteback: begin
				ctrl.regWrite = 1'b1;
			end
			mipsPkg::jump: begin
				ctrl.pcSrc   = 2'b10;
				ctrl.pcWrite = 1'b1;
			end
			default: begin
				ctrl.pcWrite = 1'b0;
			end
		endcase
	end

endmodule

// ==== hdl/datapath.sv ====
module datapath (
	input  logic                cclk,
	input  logic                rstb,
	input  mipsPkg::ctrlSignals ctrl,
	output mipsPkg::instrWord   instr,
	output logic [31:0]         memAddr,
	output logic [31:0]         memWriteData,
	input  logic [31:0]         memReadData
);

	logic [31:0] pc;
	logic [31:0] aReg;
	logic [31:0] bReg;
	logic [31:0] aluOut;
	logic [31:0] readData1;
	logic [31:0] readData2;
	logic [31:0] immExt;
	logic [31:0] srcA;
	logic [31:0] srcB;
	logic [31:0] aluResult;
	logic [31:0] jumpTarget;
	logic [31:0] pcNext;
	logic [31:0] writeData;
	logic [4:0]  writeAddr;
	logic        zero;
	logic        pcEn;

	// Program counter
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			pc <= 32'b0;
		end else if (pcEn) begin
			pc <= pcNext;
		end
	end

	// Instruction register, loaded in fetch
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			instr <= '0;
		end else if (ctrl.irWrite) begin
			instr <= memReadData;
		end
	end

	// Operand and result registers, every cycle
	always_ff @(posedge cclk) begin
		aReg   <= readData1;
		bReg   <= readData2;
		aluOut <= aluResult;
	end

	// rd for R-type, rt otherwise
	assign writeAddr = (ctrl.regDst == 2'd1) ? instr.rFields.rd : instr.rFields.rt;

	// Memory read data comes back registered from the memory itself
	assign writeData = ctrl.memToReg ? memReadData : aluOut;

	regFile regs (
		.cclk     (cclk),
		.rstb     (rstb),
		.readAddr1(instr.rFields.rs),
		.readAddr2(instr.rFields.rt),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.writeEn  (ctrl.regWrite),
		.readData1(readData1),
		.readData2(readData2)
	);

	// Sign or zero extension
	assign immExt = ctrl.extOp ? {{16{instr.iFields.imm[15]}}, instr.iFields.imm}
		: {16'b0, instr.iFields.imm};

	assign srcA = ctrl.aluSrcA ? aReg : pc;

	always_comb begin
		case (ctrl.aluSrcB)
			2'b00:   srcB = bReg;
			2'b01:   srcB = 32'd4;
			2'b10:   srcB = immExt;
			// Word offset for branches
			default: srcB = {immExt[29:0], 2'b00};
		endcase
	end

	alu aluUnit (
		.a         (srcA),
		.b         (srcB),
		.aluControl(ctrl.aluControl),
		.result    (aluResult),
		.zero      (zero)
	);

	// Region of PC+4 joined to the word target
	assign jumpTarget = {pc[31:28], instr.jFields.target, 2'b00};

	always_comb begin
		case (ctrl.pcSrc)
			2'b01:   pcNext = aluOut;
			2'b10:   pcNext = jumpTarget;
			default: pcNext = aluResult;
		endcase
	end

	// Taken beq on zero, taken bne on nonzero
	assign pcEn = ctrl.pcWrite | (ctrl.branch[0] & zero) | (ctrl.branch[1] & ~zero);

	// Single memory port
	assign memAddr      = ctrl.iOrD ? aluOut : pc;
	assign memWriteData = bReg;

endmodule

// ==== hdl/mipsCore.sv ====
module mipsCore (
	input  logic        cclk,
	input  logic        rstb,
	output logic [31:0] memAddr,
	output logic [31:0] memWriteData,
	output logic        memWrite,
	input  logic [31:0] memReadData
);

	mipsPkg::ctrlSignals ctrl;
	mipsPkg::instrWord   instr;

	// Multicycle FSM
	controlUnit ctrlUnit (
		.cclk (cclk),
		.rstb (rstb),
		.instr(instr),
		.ctrl (ctrl)
	);

	// Registers, ALU and memory addressing
	datapath dp (
		.cclk        (cclk),
		.rstb        (rstb),
		.ctrl        (ctrl),
		.instr       (instr),
		.memAddr     (memAddr),
		.memWriteData(memWriteData),
		.memReadData (memReadData)
	);

	// Write strobe straight from the FSM
	assign memWrite = ctrl.memWrite;

endmodule

// ==== sim/mipsCore_chk.sv ====
module mipsCoreChk (
	input logic                cclk,
	input logic                rstb,
	input mipsPkg::ctrlState   state,
	input mipsPkg::ctrlSignals ctrl
);

	int failCount = 0;

	// Encodings above preFetch unused
	legalState: assert property (@(posedge cclk) disable iff (!rstb)
		!$isunknown(state) && (state <= mipsPkg::preFetch))
		else begin
			failCount++;
			$error("FSM in illegal state %0d", state);
		end

	// Write strobe only while storing
	storeOnly: assert property (@(posedge cclk) disable iff (!rstb)
		ctrl.memWrite |-> (state == mipsPkg::memWrite))
		else begin
			failCount++;
			$error("memWrite high outside memWrite state");
		end

	fetchOnly: assert property (@(posedge cclk) disable iff (!rstb)
		ctrl.irWrite |-> (state == mipsPkg::fetch))
		else begin
			failCount++;
			$error("irWrite high outside fetch state");
		end

	// Synchronous reset lands in preFetch
	resetState: assert property (@(posedge cclk) !rstb |=> (state == mipsPkg::preFetch))
		else begin
			failCount++;
			$error("state after reset is not preFetch");
		end

	loadOrder: assert property (@(posedge cclk) disable iff (!rstb)
		(state == mipsPkg::memRead) |=> (state == mipsPkg::memWriteback))
		else begin
			failCount++;
			$error("memRead not followed by memWriteback");
		end

endmodule

bind controlUnit mipsCoreChk chk (
	.cclk (cclk),
	.rstb (rstb),
	.state(state),
	.ctrl (ctrl)
);

// ==== sim/mipsCoreTb.sv ====
module mipsCoreTb;

	// One expected store address and its data
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
	} storeRow;

	logic        cclk;
	logic        rstb;
	logic [31:0] memAddr;
	logic [31:0] memWriteData;
	logic        memWrite;
	logic [31:0] memReadData;

	// Program from 0 with operands at 0x200 and results from 0x280
	logic [31:0]       mem [0:255];
	logic [31:0]       dataWord [0:2];
	mipsPkg::instrWord progTable [$];
	storeRow           expTable [$];
	logic [31:0]       storeAddr;
	integer            seed = 94727;
	int                valueErrors = 0;
	int                otherErrors = 0;

	mipsCore dut (
		.cclk        (cclk),
		.rstb        (rstb),
		.memAddr     (memAddr),
		.memWriteData(memWriteData),
		.memWrite    (memWrite),
		.memReadData (memReadData)
	);

	initial begin
		cclk = 1'b0;
		forever #10 cclk = ~cclk;
	end

	// Read data one cycle after the address and writes at the end of the cycle
	always @(posedge cclk) begin
		memReadData <= mem[memAddr[9:2]];
		if (memWrite === 1'b1) begin
			mem[memAddr[9:2]] <= memWriteData;
		end
	end

	function automatic mipsPkg::instrWord rType(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		mipsPkg::instrWord w;
		w.rFields = '{mipsPkg::opRType, rs, rt, rd, 5'd0, fn};
		return w;
	endfunction

	function automatic mipsPkg::instrWord iType(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		mipsPkg::instrWord w;
		w.iFields = '{op, rs, rt, imm};
		return w;
	endfunction

	// Target is a word index
	function automatic mipsPkg::instrWord jType(input int target);
		mipsPkg::instrWord w;
		w.jFields = '{mipsPkg::opJ, target[25:0]};
		return w;
	endfunction

	// Reference results by function code
	function automatic logic [31:0] modelAlu(input logic [5:0] fn, input logic [31:0] a,
		input logic [31:0] b);
		case (fn)
			mipsPkg::fnAdd: return a + b;
			mipsPkg::fnSub: return a - b;
			mipsPkg::fnAnd: return a & b;
			mipsPkg::fnOr:  return a | b;
			mipsPkg::fnXor: return a ^ b;
			mipsPkg::fnNor: return ~(a | b);
			// Two's complement compare
			mipsPkg::fnSlt: return (signed'(a) < signed'(b)) ? 32'd1 : 32'd0;
			default:        return 32'hxxxx_xxxx;
		endcase
	endfunction

	// sw of rt to the next result slot plus its table row
	task automatic addStore(input logic [4:0] rt, input logic [31:0] data);
		progTable.push_back(iType(mipsPkg::opSw, 5'd0, rt, storeAddr[15:0]));
		expTable.push_back('{addr: storeAddr, data: data});
		storeAddr += 4;
	endtask

	// I-type op into $5 and then stored
	task automatic addImm(input logic [5:0] op, input logic [5:0] fn, input logic [4:0] rs,
		input logic [31:0] rsVal, input logic [15:0] imm, input bit signExt);
		logic [31:0] ext;
		ext = signExt ? {{16{imm[15]}}, imm} : {16'h0000, imm};
		progTable.push_back(iType(op, rs, 5'd5, imm));
		addStore(5'd5, modelAlu(fn, rsVal, ext));
	endtask

	task automatic buildProgram();
		logic [5:0] rFns [0:6] = '{mipsPkg::fnAdd, mipsPkg::fnSub, mipsPkg::fnAnd,
			mipsPkg::fnOr, mipsPkg::fnXor, mipsPkg::fnNor, mipsPkg::fnSlt};
		storeAddr = 32'h280;
		// Operands loaded and then copied out unchanged
		for (int k = 0; k < 3; k++) begin
			progTable.push_back(iType(mipsPkg::opLw, 5'd0, 5'(k + 1), 16'(32'h200 + 4 * k)));
		end
		for (int k = 0; k < 3; k++) begin
			addStore(5'(k + 1), dataWord[k]);
		end
		// Every R-type op on $1 and $2
		for (int k = 0; k < 7; k++) begin
			progTable.push_back(rType(rFns[k], 5'd4, 5'd1, 5'd2));
			addStore(5'd4, modelAlu(rFns[k], dataWord[0], dataWord[1]));
		end
		// Negative immediates sign extend while logic ones zero extend
		addImm(mipsPkg::opAddi, mipsPkg::fnAdd, 5'd1, dataWord[0], 16'hFF9C, 1'b1);
		addImm(mipsPkg::opSlti, mipsPkg::fnSlt, 5'd0, 32'd0, 16'hFFFF, 1'b1);
		addImm(mipsPkg::opSlti, mipsPkg::fnSlt, 5'd1, dataWord[0], 16'h8000, 1'b1);
		addImm(mipsPkg::opAndi, mipsPkg::fnAnd, 5'd1, dataWord[0], 16'h8F0F, 1'b0);
		addImm(mipsPkg::opOri, mipsPkg::fnOr, 5'd1, dataWord[0], 16'hF0F0, 1'b0);
		addImm(mipsPkg::opXori, mipsPkg::fnXor, 5'd1, dataWord[0], 16'hFFFF, 1'b0);
		progTable.push_back(iType(mipsPkg::opLui, 5'd0, 5'd5, 16'hBEEF));
		addStore(5'd5, 32'hBEEF_0000);
		// Skipped stores after branches aim at 0x3F0
		progTable.push_back(iType(mipsPkg::opAddi, 5'd0, 5'd6, 16'd7));
		progTable.push_back(iType(mipsPkg::opBeq, 5'd1, 5'd1, 16'd1));
		progTable.push_back(iType(mipsPkg::opSw, 5'd0, 5'd1, 16'h03F0));
		progTable.push_back(iType(mipsPkg::opBne, 5'd6, 5'd0, 16'd1));
		progTable.push_back(iType(mipsPkg::opSw, 5'd0, 5'd1, 16'h03F0));
		// Not taken so it falls into the store
		progTable.push_back(iType(mipsPkg::opBeq, 5'd6, 5'd0, 16'd1));
		addStore(5'd6, 32'd7);
		progTable.push_back(iType(mipsPkg::opBne, 5'd1, 5'd1, 16'd1));
		addStore(5'd2, dataWord[1]);
		// Jump over one store
		progTable.push_back(jType(progTable.size() + 2));
		progTable.push_back(iType(mipsPkg::opSw, 5'd0, 5'd1, 16'h03F0));
		// $0 stays zero
		progTable.push_back(iType(mipsPkg::opAddi, 5'd0, 5'd0, 16'h1234));
		addStore(5'd0, 32'd0);
		// Unknown opcode and then a jump to itself
		progTable.push_back(32'hFC00_0000);
		progTable.push_back(jType(progTable.size()));
	endtask

	task automatic compareValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			valueErrors++;
			$display("ERROR at time %0t: %s expected %h, actual %h", $time, name, expected, actual);
		end
	endtask

	// Next memWrite pulse sampled mid-cycle
	task automatic waitStore(output bit seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < 200) begin
			@(negedge cclk);
			cycles++;
			seen = (memWrite === 1'b1);
		end
	endtask

	initial begin
		bit seen;
		int assertErrors;
		rstb = 1'b0;
		memReadData = 32'b0;
		for (int i = 0; i < 256; i++) begin
			mem[i] = 32'hA500_0000 ^ (i << 2);
		end
		for (int k = 0; k < 3; k++) begin
			dataWord[k] = $random(seed);
			mem[128 + k] = dataWord[k];
		end
		buildProgram();
		foreach (progTable[k]) begin
			mem[k] = progTable[k];
		end
		// Two edges in reset
		@(negedge cclk);
		compareValue("memWrite", 32'd0, {31'd0, memWrite});
		@(posedge cclk);
		rstb <= 1'b1;
		// First preFetch
		@(negedge cclk);
		compareValue("memWrite", 32'd0, {31'd0, memWrite});
		compareValue("memAddr", 32'd0, memAddr);
		// Stores in program order
		for (int i = 0; i < expTable.size(); i++) begin
			waitStore(seen);
			assert (seen) else begin
				otherErrors++;
				$display("Store %0d to %h never came within 200 cycles", i, expTable[i].addr);
			end
			if (!seen) begin
				break;
			end
			compareValue("memAddr", expTable[i].addr, memAddr);
			compareValue("memWriteData", expTable[i].data, memWriteData);
		end
		// Core parks in the jump loop and stores no more
		if (otherErrors == 0) begin
			repeat (100) begin
				@(negedge cclk);
				assert (memWrite !== 1'b1) else begin
					otherErrors++;
					$display("Extra store to %h beyond the expected list", memAddr);
				end
			end
		end
		assertErrors = dut.ctrlUnit.chk.failCount;
		$display("Errors: %0d wrong values, %0d missing or extra stores, %0d assertion failures",
			valueErrors, otherErrors, assertErrors);
		if (valueErrors + otherErrors + assertErrors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== mipsCore.f ====
hdl/mipsPkg.sv
hdl/aluDecoder.sv
hdl/alu.sv
hdl/regFile.sv
hdl/controlUnit.sv
hdl/datapath.sv
hdl/mipsCore.sv
sim/mipsCore_chk.sv
sim/mipsCoreTb.sv
